//--- execStage.f
+incdir+verilog
verilog/execPkg.sv
verilog/execOperandIf.sv
verilog/operandForward.sv
verilog/intAlu.sv
verilog/mulDivUnit.sv
verilog/execCommit.sv
verilog/execStage.sv
tb/execChecker.sv
tb/execStageTb.sv

//--- Makefile
TOP ?= execStageTb
SEED ?= 66
LOG ?= sim.log
FLIST ?= execStage.f
VERILATOR ?= verilator

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: TOP SEED LOG FLIST VERILATOR"

test:
	$(VERILATOR) --binary -Wno-fatal --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FLIST) -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/execStageTb.sv
//######################################
// Execute stage testbench
// Table driver, credit returner, watchdog
//######################################
`timescale 1ns/100ps
`include "exec_defs.svh"

module execStageTb;
    import execPkg::*;

    parameter int SEED = 66;

    typedef struct {
        opcodeT op;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [15:0] imm;
        logic [4:0] sh;
        logic [4:0] aRs;
        logic [4:0] aRt;
        logic [4:0] mA;
        logic [31:0] mD;
        logic [4:0] wA;
        logic [31:0] wD;
        excCodeT inExcV;
        logic [31:0] expRes;
        excCodeT expExcV;
    } entryT;

    logic clk, reset, inValid, inReady, creditReturn, outValid;
    opcodeT opcode, outOpcode, expOpcode;
    logic [31:0] dataRs, dataRt, pc, memData, wbData;
    logic [31:0] outPc, outResult, outStoreData, expPc, expResult, expStore;
    logic [15:0] imm16;
    logic [4:0] shamt, addrRs, addrRt, destAddr, memAddr, wbAddr, outDestAddr, expDest;
    excCodeT inExc, outExc, expExc;
    entryT stim[$];
    int errors, tests, pendingCount, tbErrors, recCount, returned, holdStart, phaseBase;
    int seed, delay, waits, startLat;
    logic withhold;

    execStage dut0 (.*);

    execChecker checker0 (.*);

    task automatic fullEntry(input opcodeT op, input logic [31:0] rs, input logic [31:0] rt,
                             input logic [15:0] imm, input logic [4:0] sh,
                             input logic [4:0] aRs, input logic [4:0] aRt,
                             input logic [4:0] mA, input logic [31:0] mD,
                             input logic [4:0] wA, input logic [31:0] wD,
                             input excCodeT inE, input logic [31:0] res, input excCodeT exE);
        stim.push_back('{op, rs, rt, imm, sh, aRs, aRt, mA, mD, wA, wD, inE, res, exE});
    endtask

    task automatic addEntry(input opcodeT op, input logic [31:0] rs, input logic [31:0] rt,
                            input logic [15:0] imm, input logic [4:0] sh,
                            input logic [31:0] res, input excCodeT exE);
        fullEntry(op, rs, rt, imm, sh, 1, 2, 0, 0, 0, 0, EXC_NONE, res, exE);
    endtask

    // Newest stage wins and register zero never forwards
    function automatic logic [31:0] forwardedRt(input entryT e);
        if (e.mA == e.aRt && e.mA != 0)
            return e.mD;
        if (e.wA == e.aRt && e.wA != 0)
            return e.wD;
        return e.rt;
    endfunction

    // Cycles the mult/div unit stays busy after this opcode
    function automatic int busyCycles(input opcodeT op);
        if (op inside {OP_DIV, OP_DIVU})
            return `EXEC_DIV_LAT;
        if (op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU})
            return `EXEC_MUL_LAT;
        return 0;
    endfunction

    task automatic buildTable();
        addEntry(OP_ADD, 5, 7, 0, 0, 12, EXC_NONE);
        addEntry(OP_ADD, 32'h7fffffff, 1, 0, 0, 32'h80000000, EXC_OV);
        addEntry(OP_ADDU, 32'h7fffffff, 1, 0, 0, 32'h80000000, EXC_NONE);
        addEntry(OP_SUB, 32'h80000000, 1, 0, 0, 32'h7fffffff, EXC_OV);
        addEntry(OP_SUBU, 3, 5, 0, 0, 32'hfffffffe, EXC_NONE);
        addEntry(OP_ADDI, 32'h7fffffff, 0, 16'h0001, 0, 32'h80000000, EXC_OV);
        addEntry(OP_ADDIU, 0, 0, 16'hffff, 0, 32'hffffffff, EXC_NONE);
        addEntry(OP_ANDI, 32'hffffffff, 0, 16'h8001, 0, 32'h00008001, EXC_NONE);
        addEntry(OP_ORI, 32'h12340000, 0, 16'hf00f, 0, 32'h1234f00f, EXC_NONE);
        addEntry(OP_XORI, 32'hffffffff, 0, 16'h00ff, 0, 32'hffffff00, EXC_NONE);
        addEntry(OP_NOR, 32'h0f0f0f0f, 32'h00ff00ff, 0, 0, 32'hf000f000, EXC_NONE);
        addEntry(OP_XOR, 32'hff00ff00, 32'h0ff00ff0, 0, 0, 32'hf0f0f0f0, EXC_NONE);
        addEntry(OP_OR, 1, 2, 0, 0, 3, EXC_NONE);
        addEntry(OP_AND, 32'hf0f0f0f0, 32'hff00ff00, 0, 0, 32'hf000f000, EXC_NONE);
        addEntry(OP_SLT, 32'hffffffff, 1, 0, 0, 1, EXC_NONE);
        addEntry(OP_SLTU, 32'hffffffff, 1, 0, 0, 0, EXC_NONE);
        addEntry(OP_SLTI, 32'hfffffffe, 0, 16'hffff, 0, 1, EXC_NONE);
        addEntry(OP_SLTIU, 5, 0, 16'hffff, 0, 1, EXC_NONE);
        addEntry(OP_SLL, 0, 1, 0, 31, 32'h80000000, EXC_NONE);
        addEntry(OP_SRL, 0, 32'h80000000, 0, 4, 32'h08000000, EXC_NONE);
        addEntry(OP_SRA, 0, 32'h80000000, 0, 4, 32'hf8000000, EXC_NONE);
        addEntry(OP_SLLV, 36, 3, 0, 0, 32'h30, EXC_NONE);
        addEntry(OP_SRLV, 8, 32'hff000000, 0, 0, 32'h00ff0000, EXC_NONE);
        addEntry(OP_SRAV, 1, 32'hfffffff0, 0, 0, 32'hfffffff8, EXC_NONE);
        addEntry(OP_LUI, 0, 0, 16'habcd, 0, 32'habcd0000, EXC_NONE);
        addEntry(OP_CLO, 32'hffffffff, 0, 0, 0, 32, EXC_NONE);
        addEntry(OP_CLZ, 0, 0, 0, 0, 32, EXC_NONE);
        addEntry(OP_CLO, 32'hf0000000, 0, 0, 0, 4, EXC_NONE);
        addEntry(OP_CLZ, 32'h00010000, 0, 0, 0, 15, EXC_NONE);
        addEntry(OP_LW, 32'h1000, 0, 16'h0004, 0, 32'h1004, EXC_NONE);
        addEntry(OP_LW, 32'h7ffffff0, 0, 16'h0010, 0, 32'h80000000, EXC_ADEL);
        addEntry(OP_SW, 32'h80000000, 0, 16'hfffc, 0, 32'h7ffffffc, EXC_ADES);
        fullEntry(OP_ADD, 32'h7fffffff, 1, 0, 0, 1, 2, 0, 0, 0, 0, EXC_ADEL,
                  32'h80000000, EXC_ADEL);
        fullEntry(OP_ADD, 1, 1, 0, 0, 3, 4, 3, 100, 3, 200, EXC_NONE, 101, EXC_NONE);
        fullEntry(OP_ADD, 10, 1, 0, 0, 0, 4, 0, 999, 4, 50, EXC_NONE, 60, EXC_NONE);
        fullEntry(OP_SW, 32'h100, 7, 16'h8, 0, 1, 5, 0, 0, 5, 32'hdeadbeef, EXC_NONE,
                  32'h108, EXC_NONE);
        // HI/LO reads right after a start are held while busy
        addEntry(OP_MULT, 32'hfffffffd, 7, 0, 0, 0, EXC_NONE);
        addEntry(OP_MFHI, 0, 0, 0, 0, 32'hffffffff, EXC_NONE);
        addEntry(OP_MFLO, 0, 0, 0, 0, 32'hffffffeb, EXC_NONE);
        addEntry(OP_MULTU, 32'hffffffff, 2, 0, 0, 0, EXC_NONE);
        addEntry(OP_MFHI, 0, 0, 0, 0, 1, EXC_NONE);
        addEntry(OP_MFLO, 0, 0, 0, 0, 32'hfffffffe, EXC_NONE);
        addEntry(OP_DIV, 32'hfffffff9, 2, 0, 0, 0, EXC_NONE);
        addEntry(OP_MFLO, 0, 0, 0, 0, 32'hfffffffd, EXC_NONE);
        addEntry(OP_MFHI, 0, 0, 0, 0, 32'hffffffff, EXC_NONE);
        addEntry(OP_DIVU, 100, 7, 0, 0, 0, EXC_NONE);
        addEntry(OP_MFLO, 0, 0, 0, 0, 14, EXC_NONE);
        addEntry(OP_MFHI, 0, 0, 0, 0, 2, EXC_NONE);
        addEntry(OP_MTHI, 0, 0, 0, 0, 0, EXC_NONE);
        addEntry(OP_MTLO, 10, 0, 0, 0, 0, EXC_NONE);
        addEntry(OP_MADD, 3, 4, 0, 0, 0, EXC_NONE);
        addEntry(OP_MFLO, 0, 0, 0, 0, 22, EXC_NONE);
        addEntry(OP_MSUB, 5, 5, 0, 0, 0, EXC_NONE);
        addEntry(OP_MFHI, 0, 0, 0, 0, 32'hffffffff, EXC_NONE);
        addEntry(OP_MFLO, 0, 0, 0, 0, 32'hfffffffd, EXC_NONE);
        // Credit phase with three more entries than the queue holds
        holdStart = stim.size();
        for (int k = 1; k <= `EXEC_CREDIT_DEPTH + 3; k++)
            addEntry(OP_ADDU, k, 32'h100, 0, 0, 32'h100 + k, EXC_NONE);
    endtask

    task automatic driveEntry(input int i);
        entryT e;
        e = stim[i];
        opcode = e.op;
        dataRs = e.rs;
        dataRt = e.rt;
        imm16 = e.imm;
        shamt = e.sh;
        addrRs = e.aRs;
        addrRt = e.aRt;
        memAddr = e.mA;
        memData = e.mD;
        wbAddr = e.wA;
        wbData = e.wD;
        inExc = e.inExcV;
        destAddr = i[4:0];
        pc = 32'h1000 + 4 * i;
        expOpcode = e.op;
        expPc = 32'h1000 + 4 * i;
        expResult = e.expRes;
        expStore = forwardedRt(e);
        expDest = i[4:0];
        expExc = e.expExcV;
        inValid = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        inValid = 1'b0;
        creditReturn = 1'b0;
        withhold = 1'b0;
        opcode = OP_NOP;
        expOpcode = OP_NOP;
        {dataRs, dataRt, pc, memData, wbData, imm16, shamt} = '0;
        {addrRs, addrRt, destAddr, memAddr, wbAddr} = '0;
        {expPc, expResult, expStore, expDest} = '0;
        inExc = EXC_NONE;
        expExc = EXC_NONE;
        tbErrors = 0;
        recCount = 0;
        returned = 0;
        waits = 0;
        startLat = 0;
        seed = SEED;
        buildTable();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (outValid !== 1'b0) begin
            $display("[FAIL] %0t outValid expected 0 got %b", $time, outValid);
            tbErrors++;
        end
        if (inReady !== 1'b1) begin
            $display("[FAIL] %0t inReady expected 1 got %b", $time, inReady);
            tbErrors++;
        end
        for (int i = 0; i < stim.size(); i++) begin
            if (i == holdStart) begin
                while (pendingCount != 0 || recCount != returned)
                    @(negedge clk);
                withhold = 1'b1;
                phaseBase = recCount;
            end
            driveEntry(i);
            startLat = (i > 0) ? busyCycles(stim[i - 1].op) : 0;
            if (i == holdStart + `EXEC_CREDIT_DEPTH) begin
                repeat (10) begin
                    @(posedge clk);
                    if (inReady !== 1'b0) begin
                        $display("[FAIL] %0t inReady expected 0 got %b", $time, inReady);
                        tbErrors++;
                    end
                end
                if (recCount - phaseBase != `EXEC_CREDIT_DEPTH) begin
                    $display("%0d records left while credits were withheld, not %0d",
                             recCount - phaseBase, `EXEC_CREDIT_DEPTH);
                    tbErrors++;
                end
                @(negedge clk);
                withhold = 1'b0;
            end
            waits = 0;
            do begin
                @(posedge clk);
                waits++;
            end while (!inReady);
            // A HI/LO access may only be taken once the unit has drained
            if (startLat > 0 && stim[i].op inside {OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO}
                    && waits <= startLat) begin
                $display("%0t: HI/LO access at pc %h was taken %0d cycles after a start",
                         $time, pc, waits);
                tbErrors++;
            end
            @(negedge clk);
            inValid = 1'b0;
        end
        repeat (20) begin
            if (pendingCount != 0)
                @(negedge clk);
        end
        if (pendingCount != 0) begin
            $display("%0d records never arrived", pendingCount);
            tbErrors++;
        end
        $display("tests %0d, errors %0d", tests, errors + tbErrors);
        if (errors + tbErrors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    always @(posedge clk) begin
        if (outValid)
            recCount++;
    end

    // Downstream queue drains after a random delay
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && !withhold && recCount > returned) begin
                delay = $random(seed) % 7;
                if (delay < 0)
                    delay = -delay;
                repeat (delay) @(negedge clk);
                creditReturn = 1'b1;
                @(negedge clk);
                creditReturn = 1'b0;
                returned++;
            end
        end
    end

    initial begin
        wait (stim.size() > 0);
        #((stim.size() * (`EXEC_DIV_LAT + 10) + 16) * 100);
        $display("Timeout: the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- tb/execChecker.sv
//######################################
// Execute stage checker
// Matches output records to accepted entries
//######################################
`timescale 1ns/100ps
`include "exec_defs.svh"

module execChecker (
    input logic clk,
    input logic reset,
    input logic inValid,
    input logic inReady,
    input execPkg::opcodeT expOpcode,
    input logic [`EXEC_DATA_W-1:0] expPc,
    input logic [`EXEC_DATA_W-1:0] expResult,
    input logic [`EXEC_DATA_W-1:0] expStore,
    input logic [`EXEC_REG_W-1:0] expDest,
    input execPkg::excCodeT expExc,
    input logic outValid,
    input execPkg::opcodeT outOpcode,
    input logic [`EXEC_DATA_W-1:0] outPc,
    input logic [`EXEC_DATA_W-1:0] outResult,
    input logic [`EXEC_DATA_W-1:0] outStoreData,
    input logic [`EXEC_REG_W-1:0] outDestAddr,
    input execPkg::excCodeT outExc,
    output int errors,
    output int tests,
    output int pendingCount
);
    import execPkg::*;

    typedef struct packed {
        opcodeT op;
        logic [`EXEC_DATA_W-1:0] pc;
        logic [`EXEC_DATA_W-1:0] res;
        logic [`EXEC_DATA_W-1:0] store;
        logic [`EXEC_REG_W-1:0] dest;
        excCodeT exc;
        logic [31:0] cyc;
    } recordT;

    recordT pend[$];
    recordT head;
    logic [31:0] cycle;
    int bad;

    task automatic compareField(input string name, input logic [31:0] expV,
                                input logic [31:0] actV);
        if (expV !== actV) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expV, actV);
            bad++;
        end
    endtask

    initial begin
        errors = 0;
        tests = 0;
        pendingCount = 0;
        cycle = '0;
    end

    // Pop before push, a record belongs to an earlier acceptance
    always @(posedge clk) begin
        if (!reset) begin
            cycle = cycle + 1;
            if (outValid && pend.size() == 0) begin
                $display("%0t: record for pc %h came with no instruction pending",
                         $time, outPc);
                errors++;
            end else if (outValid) begin
                head = pend.pop_front();
                bad = 0;
                compareField("outOpcode", 32'(head.op), 32'(outOpcode));
                compareField("outPc", head.pc, outPc);
                compareField("outResult", head.res, outResult);
                compareField("outStoreData", head.store, outStoreData);
                compareField("outDestAddr", 32'(head.dest), 32'(outDestAddr));
                compareField("outExc", 32'(head.exc), 32'(outExc));
                if (cycle != head.cyc + 1) begin
                    $display("%0t: record for pc %h came %0d cycles after acceptance",
                             $time, outPc, cycle - head.cyc);
                    bad++;
                end
                tests++;
                errors += bad;
                $display("test %0d %s pc %h: %s", tests, head.op.name(), head.pc,
                         (bad == 0) ? "ok" : "mismatch");
            end
            if (inValid && inReady)
                pend.push_back({expOpcode, expPc, expResult, expStore, expDest, expExc, cycle});
            pendingCount = pend.size();
        end
    end

endmodule

//--- verilog/execStage.sv
//######################################
// Execute stage top level
//######################################
`timescale 1ns/100ps
`include "exec_defs.svh"

module execStage (
    input logic clk,
    input logic reset,
    // Upstream side
    input logic inValid,
    output logic inReady,
    input execPkg::opcodeT opcode,
    input logic [`EXEC_DATA_W-1:0] dataRs,
    input logic [`EXEC_DATA_W-1:0] dataRt,
    input logic [15:0] imm16,
    input logic [4:0] shamt,
    input logic [`EXEC_REG_W-1:0] addrRs,
    input logic [`EXEC_REG_W-1:0] addrRt,
    input logic [`EXEC_REG_W-1:0] destAddr,
    input logic [`EXEC_DATA_W-1:0] pc,
    input execPkg::excCodeT inExc,
    // Forwarding sources
    input logic [`EXEC_REG_W-1:0] memAddr,
    input logic [`EXEC_DATA_W-1:0] memData,
    input logic [`EXEC_REG_W-1:0] wbAddr,
    input logic [`EXEC_DATA_W-1:0] wbData,
    // Toward the memory stage
    output logic outValid,
    output execPkg::opcodeT outOpcode,
    output logic [`EXEC_DATA_W-1:0] outPc,
    output logic [`EXEC_DATA_W-1:0] outResult,
    output logic [`EXEC_DATA_W-1:0] outStoreData,
    output logic [`EXEC_REG_W-1:0] outDestAddr,
    output execPkg::excCodeT outExc,
    input logic creditReturn
);
    import execPkg::*;

    logic [`EXEC_DATA_W-1:0] aluResult;
    excCodeT aluExc;
    logic [`EXEC_DATA_W-1:0] mdResult;
    logic mdBusy;
    logic accept;

    execOperandIf ops ();

    operandForward fwd0 (
        .opcode(opcode), .dataRs(dataRs), .dataRt(dataRt), .imm16(imm16), .shamt(shamt),
        .addrRs(addrRs), .addrRt(addrRt), .memAddr(memAddr), .memData(memData),
        .wbAddr(wbAddr), .wbData(wbData), .ops(ops.fwd)
    );

    intAlu alu0 (.ops(ops.alu), .result(aluResult), .exc(aluExc));

    mulDivUnit md0 (
        .clk(clk), .reset(reset), .accept(accept), .ops(ops.md),
        .mdResult(mdResult), .mdBusy(mdBusy)
    );

    execCommit commit0 (
        .clk(clk), .reset(reset), .inValid(inValid), .opcode(opcode), .pc(pc),
        .rtData(ops.opB), .destAddr(destAddr), .inExc(inExc),
        .aluResult(aluResult), .aluExc(aluExc), .mdResult(mdResult), .mdBusy(mdBusy),
        .creditReturn(creditReturn), .accept(accept), .inReady(inReady),
        .outValid(outValid), .outOpcode(outOpcode), .outPc(outPc), .outResult(outResult),
        .outStoreData(outStoreData), .outDestAddr(outDestAddr), .outExc(outExc)
    );

endmodule

//--- verilog/execCommit.sv
//######################################
// Execute commit
// Credit flow control and output register
//######################################
`timescale 1ns/100ps
`include "exec_defs.svh"

module execCommit (
    input logic clk,
    input logic reset,
    input logic inValid,
    input execPkg::opcodeT opcode,
    input logic [`EXEC_DATA_W-1:0] pc,
    input logic [`EXEC_DATA_W-1:0] rtData,
    input logic [`EXEC_REG_W-1:0] destAddr,
    input execPkg::excCodeT inExc,
    input logic [`EXEC_DATA_W-1:0] aluResult,
    input execPkg::excCodeT aluExc,
    input logic [`EXEC_DATA_W-1:0] mdResult,
    input logic mdBusy,
    input logic creditReturn,
    output logic accept,
    output logic inReady,
    output logic outValid,
    output execPkg::opcodeT outOpcode,
    output logic [`EXEC_DATA_W-1:0] outPc,
    output logic [`EXEC_DATA_W-1:0] outResult,
    output logic [`EXEC_DATA_W-1:0] outStoreData,
    output logic [`EXEC_REG_W-1:0] outDestAddr,
    output execPkg::excCodeT outExc
);
    import execPkg::*;

    localparam logic [`EXEC_CREDIT_W-1:0] CREDIT_INIT = `EXEC_CREDIT_DEPTH;

    logic [`EXEC_CREDIT_W-1:0] credits;
    logic mdConflict;

    // Any HI/LO access waits for the unit to drain
    assign mdConflict = mdBusy && (opcode inside {[OP_MULT:OP_MFLO]});
    assign inReady = (credits != '0) && !mdConflict;
    assign accept = inValid && inReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_INIT;
        end else begin
            case ({accept, creditReturn})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            outValid <= 1'b0;
        else
            outValid <= accept;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outOpcode <= opcode;
            outPc <= pc;
            outResult <= (opcode inside {OP_MFHI, OP_MFLO}) ? mdResult : aluResult;
            outStoreData <= rtData;
            outDestAddr <= destAddr;
            // Earlier stage exception wins
            outExc <= (inExc != EXC_NONE) ? inExc : aluExc;
        end
    end

endmodule

//--- verilog/mulDivUnit.sv
//######################################
// Multiply/divide unit
// HI/LO state with a busy latency counter
//######################################
`timescale 1ns/100ps
`include "exec_defs.svh"

module mulDivUnit (
    input logic clk,
    input logic reset,
    input logic accept,
    execOperandIf.md ops,
    output logic [`EXEC_DATA_W-1:0] mdResult,
    output logic mdBusy
);
    import execPkg::*;

    localparam int W = `EXEC_DATA_W;
    localparam logic [`EXEC_LAT_W-1:0] MUL_LAT = `EXEC_MUL_LAT;
    localparam logic [`EXEC_LAT_W-1:0] DIV_LAT = `EXEC_DIV_LAT;

    logic [W-1:0] hi;
    logic [W-1:0] lo;
    logic [`EXEC_LAT_W-1:0] latCount;
    logic isUnsigned;
    logic [2*W-1:0] extA;
    logic [2*W-1:0] extB;
    logic [2*W-1:0] product;
    logic [W-1:0] quotient;
    logic [W-1:0] remainder;

    assign isUnsigned = ops.opcode inside {OP_MULTU, OP_DIVU, OP_MADDU, OP_MSUBU};

    // Extending to 64 bits makes one multiplier serve both signednesses
    assign extA = isUnsigned ? {{W{1'b0}}, ops.opA} : {{W{ops.opA[W-1]}}, ops.opA};
    assign extB = isUnsigned ? {{W{1'b0}}, ops.opB} : {{W{ops.opB[W-1]}}, ops.opB};
    assign product = extA * extB;

    always_comb begin
        if (isUnsigned) begin
            quotient = ops.opA / ops.opB;
            remainder = ops.opA % ops.opB;
        end else begin
            quotient = $signed(ops.opA) / $signed(ops.opB);
            remainder = $signed(ops.opA) % $signed(ops.opB);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
            latCount <= '0;
        end else begin
            if (latCount != '0)
                latCount <= latCount - 1'b1;
            // Starts never arrive while busy, commit holds them back
            if (accept) begin
                case (ops.opcode)
                    OP_MULT, OP_MULTU: begin
                        {hi, lo} <= product;
                        latCount <= MUL_LAT;
                    end
                    OP_DIV, OP_DIVU: begin
                        hi <= remainder;
                        lo <= quotient;
                        latCount <= DIV_LAT;
                    end
                    OP_MADD, OP_MADDU: begin
                        {hi, lo} <= {hi, lo} + product;
                        latCount <= MUL_LAT;
                    end
                    OP_MSUB, OP_MSUBU: begin
                        {hi, lo} <= {hi, lo} - product;
                        latCount <= MUL_LAT;
                    end
                    OP_MTHI: hi <= ops.opA;
                    OP_MTLO: lo <= ops.opA;
                    default: ;
                endcase
            end
        end
    end

    assign mdBusy = latCount != '0;

    assign mdResult = (ops.opcode == OP_MFHI) ? hi :
                      (ops.opcode == OP_MFLO) ? lo : '0;

endmodule

//--- verilog/intAlu.sv
//######################################
// Integer ALU
// Arithmetic, logic, shifts, CLO/CLZ, exceptions
//######################################
`timescale 1ns/100ps
`include "exec_defs.svh"

module intAlu (
    execOperandIf.alu ops,
    output logic [`EXEC_DATA_W-1:0] result,
    output execPkg::excCodeT exc
);
    import execPkg::*;

    localparam int W = `EXEC_DATA_W;
    localparam int SH_W = $clog2(`EXEC_DATA_W);

    aluOpT aluOp;
    logic isRegOp;
    logic isImmOp;
    logic isMemOp;
    logic isImmShift;
    logic zeroExt;
    logic [W-1:0] extImm;
    logic [W-1:0] srcA;
    logic [W-1:0] srcB;
    logic [W:0] wideSum;
    logic [W:0] wideDif;
    logic ovfSum;
    logic ovfDif;

    // Leading run of bitVal from the MSB
    function automatic logic [W-1:0] countLeading(input logic [W-1:0] value, input logic bitVal);
        logic done;
        logic [W-1:0] count;
        done = 1'b0;
        count = '0;
        for (int i = W - 1; i >= 0; i--) begin
            if (!done && value[i] == bitVal)
                count = count + 1'b1;
            else
                done = 1'b1;
        end
        return count;
    endfunction

    assign isRegOp = ops.opcode inside {[OP_ADD:OP_CLZ]};
    assign isImmOp = ops.opcode inside {[OP_ADDI:OP_LUI]};
    assign isMemOp = ops.opcode inside {OP_LW, OP_SW};
    assign isImmShift = ops.opcode inside {OP_SLL, OP_SRL, OP_SRA};
    assign zeroExt = ops.opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    always_comb begin
        case (ops.opcode)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_LW, OP_SW: aluOp = ALU_ADD;
            OP_SUB, OP_SUBU: aluOp = ALU_SUB;
            OP_AND, OP_ANDI: aluOp = ALU_AND;
            OP_OR, OP_ORI: aluOp = ALU_OR;
            OP_XOR, OP_XORI: aluOp = ALU_XOR;
            OP_NOR: aluOp = ALU_NOR;
            OP_SLT, OP_SLTI: aluOp = ALU_SLT;
            OP_SLTU, OP_SLTIU: aluOp = ALU_SLTU;
            OP_SLL, OP_SLLV: aluOp = ALU_SLL;
            OP_SRL, OP_SRLV: aluOp = ALU_SRL;
            OP_SRA, OP_SRAV: aluOp = ALU_SRA;
            OP_LUI: aluOp = ALU_LUI;
            OP_CLO: aluOp = ALU_CLO;
            OP_CLZ: aluOp = ALU_CLZ;
            default: aluOp = ALU_ZERO;
        endcase
    end

    assign extImm = zeroExt ? {{(W - 16){1'b0}}, ops.imm16}
                            : {{(W - 16){ops.imm16[15]}}, ops.imm16};

    // Immediate shifts take the amount from shamt
    assign srcA = isImmShift ? {{(W - 5){1'b0}}, ops.shamt} : ops.opA;
    assign srcB = (isImmOp || isMemOp) ? extImm : (isRegOp ? ops.opB : '0);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = srcA + srcB;
            ALU_SUB: result = srcA - srcB;
            ALU_AND: result = srcA & srcB;
            ALU_OR: result = srcA | srcB;
            ALU_XOR: result = srcA ^ srcB;
            ALU_NOR: result = ~(srcA | srcB);
            ALU_SLT: result = {{(W - 1){1'b0}}, $signed(srcA) < $signed(srcB)};
            ALU_SLTU: result = {{(W - 1){1'b0}}, srcA < srcB};
            ALU_SLL: result = srcB << srcA[SH_W-1:0];
            ALU_SRL: result = srcB >> srcA[SH_W-1:0];
            ALU_SRA: result = $unsigned($signed(srcB) >>> srcA[SH_W-1:0]);
            ALU_LUI: result = srcB << 16;
            ALU_CLO: result = countLeading(srcA, 1'b1);
            ALU_CLZ: result = countLeading(srcA, 1'b0);
            default: result = '0;
        endcase
    end

    // Overflow shows as a mismatch of the two top bits
    assign wideSum = {srcA[W-1], srcA} + {srcB[W-1], srcB};
    assign wideDif = {srcA[W-1], srcA} - {srcB[W-1], srcB};
    assign ovfSum = wideSum[W] != wideSum[W-1];
    assign ovfDif = wideDif[W] != wideDif[W-1];

    always_comb begin
        if (ops.opcode == OP_LW && ovfSum)
            exc = EXC_ADEL;
        else if (ops.opcode == OP_SW && ovfSum)
            exc = EXC_ADES;
        else if ((ops.opcode == OP_ADD || ops.opcode == OP_ADDI) && ovfSum)
            exc = EXC_OV;
        else if (ops.opcode == OP_SUB && ovfDif)
            exc = EXC_OV;
        else
            exc = EXC_NONE;
    end

endmodule

//--- verilog/operandForward.sv
//######################################
// Operand forwarding
// Picks MEM, WB or register-file values
//######################################
`timescale 1ns/100ps
`include "exec_defs.svh"

module operandForward (
    input execPkg::opcodeT opcode,
    input logic [`EXEC_DATA_W-1:0] dataRs,
    input logic [`EXEC_DATA_W-1:0] dataRt,
    input logic [15:0] imm16,
    input logic [4:0] shamt,
    input logic [`EXEC_REG_W-1:0] addrRs,
    input logic [`EXEC_REG_W-1:0] addrRt,
    input logic [`EXEC_REG_W-1:0] memAddr,
    input logic [`EXEC_DATA_W-1:0] memData,
    input logic [`EXEC_REG_W-1:0] wbAddr,
    input logic [`EXEC_DATA_W-1:0] wbData,
    execOperandIf.fwd ops
);

    // Newest producer wins, register zero is never forwarded
    function automatic logic [`EXEC_DATA_W-1:0] pickSource(
        input logic [`EXEC_REG_W-1:0] srcAddr,
        input logic [`EXEC_DATA_W-1:0] regValue
    );
        if (memAddr == srcAddr && memAddr != '0)
            return memData;
        if (wbAddr == srcAddr && wbAddr != '0)
            return wbData;
        return regValue;
    endfunction

    assign ops.opA = pickSource(addrRs, dataRs);
    assign ops.opB = pickSource(addrRt, dataRt);

    assign ops.opcode = opcode;
    assign ops.imm16 = imm16;
    assign ops.shamt = shamt;

endmodule

//--- verilog/execOperandIf.sv
//######################################
// Forwarded operand bundle
//######################################
`timescale 1ns/100ps
`include "exec_defs.svh"

interface execOperandIf;
    import execPkg::*;

    opcodeT opcode;
    // Operands after forwarding
    logic [`EXEC_DATA_W-1:0] opA;
    logic [`EXEC_DATA_W-1:0] opB;
    logic [15:0] imm16;
    logic [4:0] shamt;

    modport fwd (output opcode, opA, opB, imm16, shamt);

    modport alu (input opcode, opA, opB, imm16, shamt);

    // HI/LO unit needs no immediate fields
    modport md (input opcode, opA, opB);

endinterface

//--- verilog/execPkg.sv
//######################################
// Execute stage types
// Opcodes, ALU operations, exception codes
//######################################
package execPkg;

    // Classes are kept contiguous so range checks stay valid
    typedef enum logic [5:0] {
        OP_NOP,
        // R-type ALU
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_CLO, OP_CLZ,
        // I-type ALU
        OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU, OP_LUI,
        // Memory
        OP_LW, OP_SW,
        // Mult/div unit
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
        OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO
    } opcodeT;

    // Internal ALU operations
    typedef enum logic [4:0] {
        ALU_ZERO,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_CLO,
        ALU_CLZ
    } aluOpT;

    // MIPS cause codes
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV = 5'd12
    } excCodeT;

endpackage

//--- verilog/exec_defs.svh
//######################################
// Execute stage sizing macros
// Widths, credit depth and unit latencies
//######################################
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define EXEC_DATA_W 32
`define EXEC_REG_W 5

// Downstream queue size, any value from 1 to 15
`define EXEC_CREDIT_DEPTH 4
`define EXEC_CREDIT_W 4

// Busy cycles after a mult/div start
`define EXEC_MUL_LAT 5
`define EXEC_DIV_LAT 10
`define EXEC_LAT_W 4

`endif
